/* build.f */
common/csr_pkg.sv
csr/csr_decode.sv
csr/csr_cfg_regs.sv
csr/csr_status.sv
csr/csr_read_mux.sv
rtl/accel_csr_top.sv
test/tb_csr.sv

/* common/csr_pkg.sv */
// ==========================================================
// Word and address types, register map, register ids,
// field bit positions and reset values for the CSR block
// ==========================================================
`default_nettype none

package csr_pkg;

  // ==========================================================
  // Basic types
  // ==========================================================
  typedef logic [31:0] csr_word_t;  // One register or bus word
  typedef logic [7:0]  csr_addr_t;  // Byte address on host bus

  // ==========================================================
  // Address map
  // ==========================================================
  localparam csr_addr_t ADDR_CTRL     = 8'h00;  // irq_en RW, start/abort W1P
  localparam csr_addr_t ADDR_DIMS_M   = 8'h04;
  localparam csr_addr_t ADDR_DIMS_N   = 8'h08;
  localparam csr_addr_t ADDR_DIMS_K   = 8'h0C;
  localparam csr_addr_t ADDR_TILES_TM = 8'h10;
  localparam csr_addr_t ADDR_TILES_TN = 8'h14;
  localparam csr_addr_t ADDR_TILES_TK = 8'h18;
  localparam csr_addr_t ADDR_STATUS   = 8'h3C;  // Live busy plus W1C sticky bits
  // Weight DMA group
  localparam csr_addr_t ADDR_DMA_SRC  = 8'h90;
  localparam csr_addr_t ADDR_DMA_DST  = 8'h94;
  localparam csr_addr_t ADDR_DMA_LEN  = 8'h98;  // Length in bytes
  localparam csr_addr_t ADDR_DMA_CTRL = 8'h9C;  // Start W1P, busy RO, done W1C

  // Register ids out of the decoder
  typedef enum logic [3:0] {
    REG_NONE,      // Unmapped address
    REG_CTRL,
    REG_DIMS_M,
    REG_DIMS_N,
    REG_DIMS_K,
    REG_TILES_TM,
    REG_TILES_TN,
    REG_TILES_TK,
    REG_STATUS,
    REG_DMA_SRC,
    REG_DMA_DST,
    REG_DMA_LEN,
    REG_DMA_CTRL
  } csr_reg_e;

  // ==========================================================
  // Field bit positions
  // ==========================================================
  localparam int CTRL_START_BIT     = 0;
  localparam int CTRL_ABORT_BIT     = 1;
  localparam int CTRL_IRQ_EN_BIT    = 2;
  localparam int STATUS_BUSY_BIT    = 0;
  localparam int STATUS_DONE_BIT    = 1;
  localparam int STATUS_ILLEGAL_BIT = 9;
  localparam int DMA_START_BIT      = 0;
  localparam int DMA_BUSY_BIT       = 1;
  localparam int DMA_DONE_BIT       = 2;

  // Reset and filler values
  localparam csr_word_t CFG_RST_VAL    = 32'h0000_0000;  // All config words
  localparam logic      STICKY_RST_VAL = 1'b0;           // Status sticky bits
  localparam csr_word_t UNMAPPED_RDATA = 32'hDEAD_BEEF;  // Reads of holes in the map

endpackage

`default_nettype wire

/* csr/csr_cfg_regs.sv */
// ==========================================================
// Read/write configuration registers: CTRL irq_en,
// problem dims, tile sizes and weight DMA setup
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module csr_cfg_regs (
  input  wire                      clk_gated,
  input  wire                      rst_n,
  input  wire  csr_pkg::csr_reg_e  reg_sel,
  input  wire                      wr_en,
  input  wire  csr_pkg::csr_word_t csr_wdata,
  output logic                     irq_en,
  output csr_pkg::csr_word_t       dim_m,
  output csr_pkg::csr_word_t       dim_n,
  output csr_pkg::csr_word_t       dim_k,
  output csr_pkg::csr_word_t       tile_m,
  output csr_pkg::csr_word_t       tile_n,
  output csr_pkg::csr_word_t       tile_k,
  output csr_pkg::csr_word_t       dma_src_addr,
  output csr_pkg::csr_word_t       dma_dst_addr,
  output csr_pkg::csr_word_t       dma_xfer_len
);

  // ==========================================================
  // Register file
  // ==========================================================
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      irq_en       <= 1'b0;                  // Interrupts off out of reset
      dim_m        <= csr_pkg::CFG_RST_VAL;
      dim_n        <= csr_pkg::CFG_RST_VAL;
      dim_k        <= csr_pkg::CFG_RST_VAL;
      tile_m       <= csr_pkg::CFG_RST_VAL;  // Zero tiles block start
      tile_n       <= csr_pkg::CFG_RST_VAL;
      tile_k       <= csr_pkg::CFG_RST_VAL;
      dma_src_addr <= csr_pkg::CFG_RST_VAL;
      dma_dst_addr <= csr_pkg::CFG_RST_VAL;
      dma_xfer_len <= csr_pkg::CFG_RST_VAL;
    end else if (wr_en) begin
      case (reg_sel)
        // Only irq_en is stored, pulse bits live in csr_status
        csr_pkg::REG_CTRL:     irq_en       <= csr_wdata[csr_pkg::CTRL_IRQ_EN_BIT];
        // Problem dimensions
        csr_pkg::REG_DIMS_M:   dim_m        <= csr_wdata;
        csr_pkg::REG_DIMS_N:   dim_n        <= csr_wdata;
        csr_pkg::REG_DIMS_K:   dim_k        <= csr_wdata;
        // Tile sizes
        csr_pkg::REG_TILES_TM: tile_m       <= csr_wdata;
        csr_pkg::REG_TILES_TN: tile_n       <= csr_wdata;
        csr_pkg::REG_TILES_TK: tile_k       <= csr_wdata;
        // Weight DMA setup
        csr_pkg::REG_DMA_SRC:  dma_src_addr <= csr_wdata;
        csr_pkg::REG_DMA_DST:  dma_dst_addr <= csr_wdata;  // Buffer select in MSBs
        csr_pkg::REG_DMA_LEN:  dma_xfer_len <= csr_wdata;
        default: ;  // STATUS and DMA_CTRL handled in csr_status
      endcase
    end
  end

endmodule

`default_nettype wire

/* csr/csr_decode.sv */
// ==========================================================
// Address decode, write qualify and W1P request extraction
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module csr_decode (
  input  wire                      csr_wen,
  input  wire  csr_pkg::csr_addr_t csr_addr,
  input  wire  csr_pkg::csr_word_t csr_wdata,
  output csr_pkg::csr_reg_e        reg_sel,
  output logic                     wr_en,
  output logic                     start_req,
  output logic                     abort_req,
  output logic                     dma_start_req
);

  // ==========================================================
  // Address to register id
  // ==========================================================
  always_comb begin
    case (csr_addr)
      csr_pkg::ADDR_CTRL:     reg_sel = csr_pkg::REG_CTRL;
      csr_pkg::ADDR_DIMS_M:   reg_sel = csr_pkg::REG_DIMS_M;
      csr_pkg::ADDR_DIMS_N:   reg_sel = csr_pkg::REG_DIMS_N;
      csr_pkg::ADDR_DIMS_K:   reg_sel = csr_pkg::REG_DIMS_K;
      csr_pkg::ADDR_TILES_TM: reg_sel = csr_pkg::REG_TILES_TM;
      csr_pkg::ADDR_TILES_TN: reg_sel = csr_pkg::REG_TILES_TN;
      csr_pkg::ADDR_TILES_TK: reg_sel = csr_pkg::REG_TILES_TK;
      csr_pkg::ADDR_STATUS:   reg_sel = csr_pkg::REG_STATUS;
      csr_pkg::ADDR_DMA_SRC:  reg_sel = csr_pkg::REG_DMA_SRC;
      csr_pkg::ADDR_DMA_DST:  reg_sel = csr_pkg::REG_DMA_DST;
      csr_pkg::ADDR_DMA_LEN:  reg_sel = csr_pkg::REG_DMA_LEN;
      csr_pkg::ADDR_DMA_CTRL: reg_sel = csr_pkg::REG_DMA_CTRL;
      default:                reg_sel = csr_pkg::REG_NONE;  // Hole in map
    endcase
  end

  // Writes to holes are dropped here
  assign wr_en = csr_wen && (reg_sel != csr_pkg::REG_NONE);

  // ==========================================================
  // Write-one-pulse requests
  // ==========================================================
  // CTRL start and abort
  assign start_req = wr_en && (reg_sel == csr_pkg::REG_CTRL)
                     && csr_wdata[csr_pkg::CTRL_START_BIT];
  assign abort_req = wr_en && (reg_sel == csr_pkg::REG_CTRL)
                     && csr_wdata[csr_pkg::CTRL_ABORT_BIT];

  // DMA kick
  assign dma_start_req = wr_en && (reg_sel == csr_pkg::REG_DMA_CTRL)
                         && csr_wdata[csr_pkg::DMA_START_BIT];

endmodule

`default_nettype wire

/* csr/csr_read_mux.sv */
// ==========================================================
// Combinational read data selection by register id
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux (
  input  wire  csr_pkg::csr_reg_e  reg_sel,
  input  wire                      irq_en,
  input  wire                      done_tile,
  input  wire                      err_illegal,
  input  wire                      dma_done,
  input  wire                      core_busy,
  input  wire                      dma_busy,
  input  wire  csr_pkg::csr_word_t dim_m,
  input  wire  csr_pkg::csr_word_t dim_n,
  input  wire  csr_pkg::csr_word_t dim_k,
  input  wire  csr_pkg::csr_word_t tile_m,
  input  wire  csr_pkg::csr_word_t tile_n,
  input  wire  csr_pkg::csr_word_t tile_k,
  input  wire  csr_pkg::csr_word_t dma_src_addr,
  input  wire  csr_pkg::csr_word_t dma_dst_addr,
  input  wire  csr_pkg::csr_word_t dma_xfer_len,
  output csr_pkg::csr_word_t       csr_rdata
);

  // ==========================================================
  // Read mux
  // ==========================================================
  always_comb begin
    csr_rdata = '0;  // Reserved bits read zero
    case (reg_sel)
      // W1P start/abort read back as 0
      csr_pkg::REG_CTRL:     csr_rdata[csr_pkg::CTRL_IRQ_EN_BIT] = irq_en;
      csr_pkg::REG_DIMS_M:   csr_rdata = dim_m;
      csr_pkg::REG_DIMS_N:   csr_rdata = dim_n;
      csr_pkg::REG_DIMS_K:   csr_rdata = dim_k;
      csr_pkg::REG_TILES_TM: csr_rdata = tile_m;
      csr_pkg::REG_TILES_TN: csr_rdata = tile_n;
      csr_pkg::REG_TILES_TK: csr_rdata = tile_k;
      csr_pkg::REG_STATUS: begin
        csr_rdata[csr_pkg::STATUS_BUSY_BIT]    = core_busy;  // Live
        csr_rdata[csr_pkg::STATUS_DONE_BIT]    = done_tile;
        csr_rdata[csr_pkg::STATUS_ILLEGAL_BIT] = err_illegal;
      end
      csr_pkg::REG_DMA_SRC:  csr_rdata = dma_src_addr;
      csr_pkg::REG_DMA_DST:  csr_rdata = dma_dst_addr;
      csr_pkg::REG_DMA_LEN:  csr_rdata = dma_xfer_len;
      csr_pkg::REG_DMA_CTRL: begin
        csr_rdata[csr_pkg::DMA_BUSY_BIT] = dma_busy;  // Live from engine
        csr_rdata[csr_pkg::DMA_DONE_BIT] = dma_done;
      end
      default:               csr_rdata = csr_pkg::UNMAPPED_RDATA;
    endcase
  end

endmodule

`default_nettype wire

/* csr/csr_status.sv */
// ==========================================================
// Sticky status bits, start guard and W1P pulse outputs
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module csr_status (
  input  wire                      clk_gated,
  input  wire                      rst_n,
  input  wire  csr_pkg::csr_reg_e  reg_sel,
  input  wire                      wr_en,
  input  wire  csr_pkg::csr_word_t csr_wdata,
  input  wire                      start_req,
  input  wire                      abort_req,
  input  wire                      dma_start_req,
  input  wire                      core_busy,
  input  wire                      core_done_tile,  // One-cycle event
  input  wire                      dma_done_evt,    // One-cycle event
  input  wire  csr_pkg::csr_word_t tile_m,
  input  wire  csr_pkg::csr_word_t tile_n,
  input  wire  csr_pkg::csr_word_t tile_k,
  output logic                     done_tile,
  output logic                     err_illegal,
  output logic                     dma_done,
  output logic                     start_pulse,
  output logic                     abort_pulse,
  output logic                     dma_start_pulse
);

  logic tiles_ok;     // All tile sizes non-zero
  logic start_ok;     // Start may go to the core
  logic wr_status;    // Write hits STATUS
  logic wr_dma_ctrl;  // Write hits DMA_CTRL

  // ==========================================================
  // Start guard
  // ==========================================================
  assign tiles_ok = (tile_m != '0) && (tile_n != '0) && (tile_k != '0);
  assign start_ok = !core_busy && tiles_ok;

  assign start_pulse     = start_req && start_ok;
  assign abort_pulse     = abort_req;      // Abort is never refused
  assign dma_start_pulse = dma_start_req;  // DMA engine keeps its own busy

  assign wr_status   = wr_en && (reg_sel == csr_pkg::REG_STATUS);
  assign wr_dma_ctrl = wr_en && (reg_sel == csr_pkg::REG_DMA_CTRL);

  // ==========================================================
  // Sticky bits
  // ==========================================================
  // W1C first, events after so a same-cycle set wins
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      done_tile   <= csr_pkg::STICKY_RST_VAL;
      err_illegal <= csr_pkg::STICKY_RST_VAL;
      dma_done    <= csr_pkg::STICKY_RST_VAL;
    end else begin
      if (wr_status && csr_wdata[csr_pkg::STATUS_DONE_BIT])    done_tile   <= 1'b0;
      if (wr_status && csr_wdata[csr_pkg::STATUS_ILLEGAL_BIT]) err_illegal <= 1'b0;
      if (wr_dma_ctrl && csr_wdata[csr_pkg::DMA_DONE_BIT])     dma_done    <= 1'b0;
      if (core_done_tile)         done_tile   <= 1'b1;
      if (start_req && !start_ok) err_illegal <= 1'b1;  // Refused start
      if (dma_done_evt)           dma_done    <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/accel_csr_top.sv */
// ==========================================================
// CSR block top: decode, config regs, status, read mux
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module accel_csr_top (
  input  wire                      clk_gated,
  input  wire                      rst_n,
  // Host bus
  input  wire                      csr_wen,
  input  wire  csr_pkg::csr_addr_t csr_addr,
  input  wire  csr_pkg::csr_word_t csr_wdata,
  output csr_pkg::csr_word_t       csr_rdata,
  // Core and DMA events
  input  wire                      core_busy,
  input  wire                      core_done_tile,
  input  wire                      dma_busy,
  input  wire                      dma_done_evt,
  // To core
  output logic                     start_pulse,
  output logic                     abort_pulse,
  output logic                     irq_en,
  output csr_pkg::csr_word_t       dim_m,
  output csr_pkg::csr_word_t       dim_n,
  output csr_pkg::csr_word_t       dim_k,
  output csr_pkg::csr_word_t       tile_m,
  output csr_pkg::csr_word_t       tile_n,
  output csr_pkg::csr_word_t       tile_k,
  // To weight DMA
  output csr_pkg::csr_word_t       dma_src_addr,
  output csr_pkg::csr_word_t       dma_dst_addr,
  output csr_pkg::csr_word_t       dma_xfer_len,
  output logic                     dma_start_pulse
);

  csr_pkg::csr_reg_e reg_sel;  // Decoded register id
  logic              wr_en;    // Mapped write
  logic              start_req;
  logic              abort_req;
  logic              dma_start_req;
  logic              done_tile;
  logic              err_illegal;
  logic              dma_done;

  // ==========================================================
  // Instances
  // ==========================================================
  csr_decode i_decode (
    .csr_wen, .csr_addr, .csr_wdata,
    .reg_sel, .wr_en, .start_req, .abort_req, .dma_start_req
  );

  csr_cfg_regs i_cfg_regs (
    .clk_gated, .rst_n, .reg_sel, .wr_en, .csr_wdata,
    .irq_en, .dim_m, .dim_n, .dim_k, .tile_m, .tile_n, .tile_k,
    .dma_src_addr, .dma_dst_addr, .dma_xfer_len
  );

  csr_status i_status (
    .clk_gated, .rst_n, .reg_sel, .wr_en, .csr_wdata,
    .start_req, .abort_req, .dma_start_req,
    .core_busy, .core_done_tile, .dma_done_evt,
    .tile_m, .tile_n, .tile_k,
    .done_tile, .err_illegal, .dma_done,
    .start_pulse, .abort_pulse, .dma_start_pulse
  );

  csr_read_mux i_read_mux (
    .reg_sel, .irq_en, .done_tile, .err_illegal, .dma_done, .core_busy, .dma_busy,
    .dim_m, .dim_n, .dim_k, .tile_m, .tile_n, .tile_k,
    .dma_src_addr, .dma_dst_addr, .dma_xfer_len,
    .csr_rdata
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the CSR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_csr -Mdir obj_dir -o sim_csr
./obj_dir/sim_csr | tee sim.log

# Pass only when the testbench printed its pass line
grep -q "^Test passed$" sim.log

/* test/tb_csr.sv */
// ==========================================================
// CSR block testbench: reference model, bus tasks, checks
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tb_csr;

  localparam int MAX_CYCLES = 2000;  // Far above the ~170 cycles all tests take

  logic clk_gated = 1'b0;
  logic rst_n;
  logic csr_wen;
  csr_pkg::csr_addr_t csr_addr;
  csr_pkg::csr_word_t csr_wdata;
  csr_pkg::csr_word_t csr_rdata;
  logic core_busy, core_done_tile, dma_busy, dma_done_evt;
  logic start_pulse, abort_pulse, irq_en, dma_start_pulse;
  csr_pkg::csr_word_t dim_m, dim_n, dim_k, tile_m, tile_n, tile_k;
  csr_pkg::csr_word_t dma_src_addr, dma_dst_addr, dma_xfer_len;

  // ==========================================================
  // Reference model state and counters
  // ==========================================================
  csr_pkg::csr_word_t sh_word [0:255];  // Plain RW words by address
  csr_pkg::csr_addr_t cfg_addr [0:8];
  logic sh_irq_en, sh_done, sh_illegal, sh_dma_done;
  logic seen_start, seen_abort, seen_dma;  // Pulses seen in write cycle
  int cycle_cnt = 0;
  int err_cnt = 0;
  int test_err = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  integer seed = 12162;
  csr_pkg::csr_word_t rnd;

  accel_csr_top i_dut (
    .clk_gated, .rst_n, .csr_wen, .csr_addr, .csr_wdata, .csr_rdata,
    .core_busy, .core_done_tile, .dma_busy, .dma_done_evt,
    .start_pulse, .abort_pulse, .irq_en, .dim_m, .dim_n, .dim_k,
    .tile_m, .tile_n, .tile_k, .dma_src_addr, .dma_dst_addr, .dma_xfer_len,
    .dma_start_pulse
  );

  always #5 clk_gated = ~clk_gated;  // 10 ns period

  always @(posedge clk_gated) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic tiles_ok_ref();
    return (sh_word[csr_pkg::ADDR_TILES_TM] != 0) && (sh_word[csr_pkg::ADDR_TILES_TN] != 0)
           && (sh_word[csr_pkg::ADDR_TILES_TK] != 0);
  endfunction

  // Expected read word from the shadow state
  function automatic csr_pkg::csr_word_t expected_rdata(input csr_pkg::csr_addr_t addr);
    csr_pkg::csr_word_t r;
    r = '0;
    case (addr)
      csr_pkg::ADDR_CTRL: r[csr_pkg::CTRL_IRQ_EN_BIT] = sh_irq_en;  // Pulse bits read 0
      csr_pkg::ADDR_STATUS: begin
        r[csr_pkg::STATUS_BUSY_BIT]    = core_busy;
        r[csr_pkg::STATUS_DONE_BIT]    = sh_done;
        r[csr_pkg::STATUS_ILLEGAL_BIT] = sh_illegal;
      end
      csr_pkg::ADDR_DMA_CTRL: begin
        r[csr_pkg::DMA_BUSY_BIT] = dma_busy;
        r[csr_pkg::DMA_DONE_BIT] = sh_dma_done;
      end
      csr_pkg::ADDR_DIMS_M, csr_pkg::ADDR_DIMS_N, csr_pkg::ADDR_DIMS_K,
      csr_pkg::ADDR_TILES_TM, csr_pkg::ADDR_TILES_TN, csr_pkg::ADDR_TILES_TK,
      csr_pkg::ADDR_DMA_SRC, csr_pkg::ADDR_DMA_DST, csr_pkg::ADDR_DMA_LEN: r = sh_word[addr];
      default: r = csr_pkg::UNMAPPED_RDATA;
    endcase
    return r;
  endfunction

  // ==========================================================
  // Compare and bus tasks
  // ==========================================================
  task automatic check_word(input csr_pkg::csr_word_t got, input csr_pkg::csr_word_t exp,
                            input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_err == 0) begin
      pass_cnt++;
      $display("%-22s ok (0 errors)", name);
    end else begin
      fail_cnt++;
      $display("%-22s FAILED (%0d errors)", name, test_err);
    end
    test_err = 0;
  endtask

  // One write cycle, pulses checked in it and in the cycle after
  task automatic write_reg(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_word_t data);
    logic exp_s;
    logic is_ctrl;
    @(negedge clk_gated);
    csr_wen   = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    is_ctrl   = (addr == csr_pkg::ADDR_CTRL);
    exp_s     = is_ctrl && data[csr_pkg::CTRL_START_BIT] && !core_busy && tiles_ok_ref();
    #2;
    seen_start = start_pulse;
    seen_abort = abort_pulse;
    seen_dma   = dma_start_pulse;
    check_bit(start_pulse, exp_s, "start_pulse in write cycle");
    check_bit(abort_pulse, is_ctrl && data[csr_pkg::CTRL_ABORT_BIT], "abort_pulse in write cycle");
    check_bit(dma_start_pulse, (addr == csr_pkg::ADDR_DMA_CTRL) && data[csr_pkg::DMA_START_BIT],
              "dma_start_pulse in write cycle");
    @(posedge clk_gated);
    case (addr)  // Shadow update, clear before set
      csr_pkg::ADDR_CTRL: begin
        sh_irq_en = data[csr_pkg::CTRL_IRQ_EN_BIT];
        if (data[csr_pkg::CTRL_START_BIT] && !exp_s) sh_illegal = 1'b1;  // Refused
      end
      csr_pkg::ADDR_STATUS: begin
        if (data[csr_pkg::STATUS_DONE_BIT]) sh_done = 1'b0;
        if (data[csr_pkg::STATUS_ILLEGAL_BIT]) sh_illegal = 1'b0;
      end
      csr_pkg::ADDR_DMA_CTRL: if (data[csr_pkg::DMA_DONE_BIT]) sh_dma_done = 1'b0;
      csr_pkg::ADDR_DIMS_M, csr_pkg::ADDR_DIMS_N, csr_pkg::ADDR_DIMS_K,
      csr_pkg::ADDR_TILES_TM, csr_pkg::ADDR_TILES_TN, csr_pkg::ADDR_TILES_TK,
      csr_pkg::ADDR_DMA_SRC, csr_pkg::ADDR_DMA_DST, csr_pkg::ADDR_DMA_LEN: sh_word[addr] = data;
      default: ;  // Hole in the map, write dropped
    endcase
    @(negedge clk_gated);
    csr_wen = 1'b0;
    #2;
    check_bit(start_pulse | abort_pulse | dma_start_pulse, 1'b0, "pulses one cycle later");
  endtask

  task automatic read_check(input csr_pkg::csr_addr_t addr, input string what);
    @(negedge clk_gated);
    csr_wen  = 1'b0;
    csr_addr = addr;
    #2;  // Read path is combinational
    check_word(csr_rdata, expected_rdata(addr), $sformatf("%s at %h", what, addr));
  endtask

  task automatic fire_event(input logic is_dma);
    @(negedge clk_gated);
    if (is_dma) dma_done_evt = 1'b1;
    else core_done_tile = 1'b1;
    @(posedge clk_gated);
    if (is_dma) sh_dma_done = 1'b1;
    else sh_done = 1'b1;
    @(negedge clk_gated);
    dma_done_evt   = 1'b0;
    core_done_tile = 1'b0;
  endtask

  // ==========================================================
  // Tests
  // ==========================================================
  initial begin
    rst_n = 1'b0;
    csr_wen = 1'b0;
    csr_addr = '0;
    csr_wdata = '0;
    core_busy = 1'b0;
    core_done_tile = 1'b0;
    dma_busy = 1'b0;
    dma_done_evt = 1'b0;
    {sh_irq_en, sh_done, sh_illegal, sh_dma_done} = '0;
    foreach (sh_word[i]) sh_word[i] = '0;
    cfg_addr = '{csr_pkg::ADDR_DIMS_M, csr_pkg::ADDR_DIMS_N, csr_pkg::ADDR_DIMS_K,
                 csr_pkg::ADDR_TILES_TM, csr_pkg::ADDR_TILES_TN, csr_pkg::ADDR_TILES_TK,
                 csr_pkg::ADDR_DMA_SRC, csr_pkg::ADDR_DMA_DST, csr_pkg::ADDR_DMA_LEN};
    repeat (3) @(posedge clk_gated);
    @(negedge clk_gated);
    rst_n = 1'b1;

    // Reset values, holes read filler
    for (int a = 0; a < 256; a += 4) read_check(csr_pkg::csr_addr_t'(a), "reset read");
    check_bit(start_pulse | abort_pulse | dma_start_pulse, 1'b0, "pulses after reset");
    check_bit(irq_en, 1'b0, "irq_en after reset");
    end_test("reset values");

    foreach (cfg_addr[i]) begin
      rnd = $random(seed);
      write_reg(cfg_addr[i], rnd);
    end
    foreach (cfg_addr[i]) read_check(cfg_addr[i], "config readback");
    check_word(dim_m, sh_word[csr_pkg::ADDR_DIMS_M], "dim_m output");
    check_word(dim_n, sh_word[csr_pkg::ADDR_DIMS_N], "dim_n output");
    check_word(dim_k, sh_word[csr_pkg::ADDR_DIMS_K], "dim_k output");
    check_word(tile_m, sh_word[csr_pkg::ADDR_TILES_TM], "tile_m output");
    check_word(tile_n, sh_word[csr_pkg::ADDR_TILES_TN], "tile_n output");
    check_word(tile_k, sh_word[csr_pkg::ADDR_TILES_TK], "tile_k output");
    check_word(dma_src_addr, sh_word[csr_pkg::ADDR_DMA_SRC], "dma_src_addr output");
    check_word(dma_dst_addr, sh_word[csr_pkg::ADDR_DMA_DST], "dma_dst_addr output");
    check_word(dma_xfer_len, sh_word[csr_pkg::ADDR_DMA_LEN], "dma_xfer_len output");
    rnd = $random(seed);
    write_reg(csr_pkg::ADDR_CTRL, rnd | (32'h1 << csr_pkg::CTRL_IRQ_EN_BIT));
    read_check(csr_pkg::ADDR_CTRL, "CTRL keeps only irq_en");
    check_bit(irq_en, 1'b1, "irq_en output");
    end_test("config readback");

    // Start guard
    write_reg(csr_pkg::ADDR_STATUS, 32'h1 << csr_pkg::STATUS_ILLEGAL_BIT);
    write_reg(csr_pkg::ADDR_TILES_TM, $random(seed) | 32'h1);
    write_reg(csr_pkg::ADDR_TILES_TN, $random(seed) | 32'h1);
    write_reg(csr_pkg::ADDR_TILES_TK, $random(seed) | 32'h1);
    write_reg(csr_pkg::ADDR_CTRL, 32'h1 << csr_pkg::CTRL_START_BIT);
    check_bit(seen_start, 1'b1, "start accepted");
    read_check(csr_pkg::ADDR_STATUS, "STATUS after good start");
    check_bit(csr_rdata[csr_pkg::STATUS_ILLEGAL_BIT], 1'b0, "no error on good start");
    write_reg(csr_pkg::ADDR_TILES_TK, '0);
    write_reg(csr_pkg::ADDR_CTRL, 32'h1 << csr_pkg::CTRL_START_BIT);
    check_bit(seen_start, 1'b0, "start with zero tile refused");
    read_check(csr_pkg::ADDR_STATUS, "STATUS after zero tile start");
    check_bit(csr_rdata[csr_pkg::STATUS_ILLEGAL_BIT], 1'b1, "err_illegal on zero tile");
    write_reg(csr_pkg::ADDR_TILES_TK, 32'h10);
    write_reg(csr_pkg::ADDR_STATUS, 32'h1 << csr_pkg::STATUS_ILLEGAL_BIT);
    @(negedge clk_gated);
    core_busy = 1'b1;  // Core still running
    write_reg(csr_pkg::ADDR_CTRL, 32'h1 << csr_pkg::CTRL_START_BIT);
    check_bit(seen_start, 1'b0, "start while busy refused");
    read_check(csr_pkg::ADDR_STATUS, "STATUS after busy start");
    check_bit(csr_rdata[csr_pkg::STATUS_ILLEGAL_BIT], 1'b1, "err_illegal on busy start");
    @(negedge clk_gated);
    core_busy = 1'b0;
    end_test("start guard");

    // Sticky bits
    write_reg(csr_pkg::ADDR_STATUS, 32'h1 << csr_pkg::STATUS_ILLEGAL_BIT);
    read_check(csr_pkg::ADDR_STATUS, "err_illegal cleared by bit 9");
    fire_event(1'b0);
    write_reg(csr_pkg::ADDR_DIMS_M, $random(seed));
    write_reg(csr_pkg::ADDR_STATUS, '0);  // Zero write keeps it
    read_check(csr_pkg::ADDR_STATUS, "done_tile holds");
    check_bit(csr_rdata[csr_pkg::STATUS_DONE_BIT], 1'b1, "done_tile set and held");
    write_reg(csr_pkg::ADDR_STATUS, 32'h1 << csr_pkg::STATUS_DONE_BIT);
    read_check(csr_pkg::ADDR_STATUS, "done_tile cleared");
    fire_event(1'b1);
    write_reg(csr_pkg::ADDR_DMA_LEN, $random(seed));
    write_reg(csr_pkg::ADDR_DMA_CTRL, '0);
    read_check(csr_pkg::ADDR_DMA_CTRL, "dma_done holds");
    check_bit(csr_rdata[csr_pkg::DMA_DONE_BIT], 1'b1, "dma_done set and held");
    write_reg(csr_pkg::ADDR_DMA_CTRL, 32'h1 << csr_pkg::DMA_DONE_BIT);
    read_check(csr_pkg::ADDR_DMA_CTRL, "dma_done cleared");
    end_test("sticky bits");

    // Pulses and live busy bits
    write_reg(csr_pkg::ADDR_CTRL, 32'h1 << csr_pkg::CTRL_ABORT_BIT);
    check_bit(seen_abort, 1'b1, "abort pulse");
    write_reg(csr_pkg::ADDR_DMA_CTRL, 32'h1 << csr_pkg::DMA_START_BIT);
    check_bit(seen_dma, 1'b1, "DMA start pulse");
    read_check(csr_pkg::ADDR_CTRL, "CTRL start bit reads 0");
    read_check(csr_pkg::ADDR_DMA_CTRL, "DMA start bit reads 0");
    @(negedge clk_gated);
    core_busy = 1'b1;
    dma_busy  = 1'b1;
    read_check(csr_pkg::ADDR_STATUS, "core busy live high");
    read_check(csr_pkg::ADDR_DMA_CTRL, "DMA busy live high");
    check_bit(csr_rdata[csr_pkg::DMA_BUSY_BIT], 1'b1, "DMA busy bit");
    @(negedge clk_gated);
    core_busy = 1'b0;
    dma_busy  = 1'b0;
    read_check(csr_pkg::ADDR_STATUS, "core busy live low");
    read_check(csr_pkg::ADDR_DMA_CTRL, "DMA busy live low");
    end_test("pulses and live bits");

    $display("Tests: %0d ok, %0d failed, %0d mismatches", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
